//--- project.f
+incdir+rtl
rtl/pacer_pkg.sv
rtl/msg_assembler.sv
rtl/sync_fifo.sv
rtl/bank_controller.sv
rtl/frame_pacer.sv
rtl/pulse_list_top.sv
test/tb_pulse_list.sv

//--- Makefile
TOP = tb_pulse_list
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module pulse_list_top
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_pulse_list.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module tb_pulse_list;
  import pacer_pkg::*;

  typedef struct packed {
    logic [31:0] n_frame;
    logic [31:0] clk_per_frame;
    logic [31:0] stop_after;    // cycles after app_running rises, 0 = run to the end
    logic [31:0] exp_frames;    // unused when the run is stopped early
  } test_row_t;

  localparam int NUM_TESTS = 5;

  localparam test_row_t TESTS [NUM_TESTS] = '{
    '{32'd3,  32'd300, 32'd0,   32'd3},
    '{32'd50, 32'd300, 32'd500, 32'd0},   // stopped long before the end
    '{32'd2,  32'd250, 32'd0,   32'd2},
    '{32'd4,  32'd200, 32'd0,   32'd4},
    '{32'd3,  32'd50,  32'd0,   32'd3}    // copy overruns the period
  };

  logic                CLK = 1'b0;
  logic                RESET;
  logic                pc_msg_valid;
  logic [`XB_SIZE-1:0] pc_msg;
  logic                pc_msg_ack;
  logic                app_running;
  logic                app_error;
  count_t              frame_count;

  int          num_checks = 0;
  int          num_errors = 0;
  int unsigned cycle = 0;
  int unsigned limit;

  pulse_list_top UUT (
    .CLK(CLK),
    .RESET(RESET),
    .pc_msg_valid(pc_msg_valid),
    .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack),
    .app_running(app_running),
    .app_error(app_error),
    .frame_count(frame_count)
  );

  always #20 CLK = ~CLK;

  // cycle count, also ends a run that never finishes
  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("timeout after %0d cycles, the DUT did not finish its runs in time", cycle);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    num_checks++;
    if (actual !== expected) begin
      num_errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // step to the next edge, inputs change just after it
  task automatic tick();
    @(posedge CLK);
    #2;
  endtask

  function automatic logic [`MSG_SIZE-1:0] build_msg(input logic data_type,
                                                    input logic start,
                                                    input logic [31:0] n_frame,
                                                    input logic [31:0] clk_per_frame);
    logic [`MSG_SIZE-1:0] m;
    m = '0;
    m[`MSG_TYPE_BIT] = data_type;
    m[`MSG_START_BIT] = start;
    m[`N_FRAME_BIT +: `N_FRAME_SIZE] = n_frame[`N_FRAME_SIZE-1:0];
    m[`CLK_PER_FRAME_BIT +: `CLK_PER_FRAME_SIZE] = clk_per_frame[`CLK_PER_FRAME_SIZE-1:0];
    return m;
  endfunction

  // lowest word goes first
  task automatic send_msg(input logic [`MSG_SIZE-1:0] msg);
    for (int w = 0; w < 3; w++) begin
      pc_msg_valid = 1'b1;
      pc_msg = msg[w*`XB_SIZE +: `XB_SIZE];
      #1;
      check("ack during message", 32'd1, 32'(pc_msg_ack));
      tick();
    end
    pc_msg_valid = 1'b0;
    pc_msg = '0;
  endtask

  task automatic wait_running(input logic level);
    while (app_running !== level) tick();
  endtask

  function automatic int unsigned timeout_limit();
    int unsigned sum;
    sum = 2000;
    for (int i = 0; i < NUM_TESTS; i++) begin
      sum += TESTS[i].n_frame * (TESTS[i].clk_per_frame + 400);
    end
    return sum;
  endfunction

  initial begin
    test_row_t   t;
    string       name;
    int unsigned rise;
    int unsigned fall;
    logic        saw_run;
    logic [31:0] min_cycles;

    limit = timeout_limit();
    RESET = 1'b1;
    pc_msg_valid = 1'b0;
    pc_msg = '0;
    repeat (8) tick();
    RESET = 1'b0;
    tick();

    // state right after reset
    check("reset app_running", 32'd0, 32'(app_running));
    check("reset app_error", 32'd0, 32'(app_error));
    check("reset frame_count", 32'd0, 32'(frame_count));
    check("ack low without valid", 32'd0, 32'(pc_msg_ack));
    pc_msg_valid = 1'b1;
    #1;
    check("ack follows valid high", 32'd1, 32'(pc_msg_ack));
    pc_msg_valid = 1'b0;
    #1;
    check("ack follows valid low", 32'd0, 32'(pc_msg_ack));
    tick();

    // data message with the start bit set must not start anything
    send_msg(build_msg(1'b1, 1'b1, 32'd5, 32'd100));
    saw_run = 1'b0;
    repeat (200) begin
      tick();
      saw_run = saw_run | app_running;
    end
    check("data message starts no run", 32'd0, 32'(saw_run));
    check("data message frame_count", 32'd0, 32'(frame_count));

    for (int i = 0; i < NUM_TESTS; i++) begin
      t = TESTS[i];
      name = $sformatf("test %0d (%0d frames, %0d clk)", i, t.n_frame, t.clk_per_frame);
      send_msg(build_msg(1'b0, 1'b1, t.n_frame, t.clk_per_frame));
      wait_running(1'b1);
      rise = cycle;
      if (t.stop_after != 0) begin
        repeat (t.stop_after) tick();
        send_msg(build_msg(1'b0, 1'b0, 32'd0, 32'd0));   // stop
      end
      wait_running(1'b0);
      fall = cycle;
      check({name, " app_error"}, 32'd0, 32'(app_error));
      if (t.stop_after != 0) begin
        check({name, " stopped below frame limit"}, 32'd1,
              32'(32'(frame_count) < t.n_frame));
      end else begin
        check({name, " frame_count"}, t.exp_frames, 32'(frame_count));
        // the last frame does not wait out its period
        min_cycles = (t.n_frame - 1) * t.clk_per_frame;
        check($sformatf("%s run at least %0d cycles", name, min_cycles), 32'd1,
              32'(32'(fall - rise) >= min_cycles));
      end
      repeat (10) tick();
      check({name, " still stopped"}, 32'd0, 32'(app_running));
    end

    $display("checks: %0d  errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- rtl/pulse_list_top.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module pulse_list_top (
  input  logic                CLK,
  input  logic                RESET,
  input  logic                pc_msg_valid,
  input  logic [`XB_SIZE-1:0] pc_msg,
  output logic                pc_msg_ack,
  output logic                app_running,
  output logic                app_error,
  output pacer_pkg::count_t   frame_count
);
  import pacer_pkg::*;

  logic       cmd_valid, is_start, is_stop;
  count_t     n_frame_max, clk_per_frame;
  logic [1:0] cmd_push, cmd_high, rd_valid, rd_pop;
  bank_cmd_t  cmd0, cmd1;
  word_t      rd_word0, rd_word1;

  msg_assembler u_asm (
    .CLK(CLK),
    .RESET(RESET),
    .pc_msg_valid(pc_msg_valid),
    .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack),
    .cmd_valid(cmd_valid),
    .is_start(is_start),
    .is_stop(is_stop),
    .n_frame_max(n_frame_max),
    .clk_per_frame(clk_per_frame)
  );

  // ping-pong pair
  bank_controller u_bank0 (
    .CLK(CLK), .RESET(RESET),
    .cmd_push(cmd_push[0]), .cmd(cmd0), .cmd_high(cmd_high[0]),
    .rd_pop(rd_pop[0]), .rd_valid(rd_valid[0]), .rd_word(rd_word0)
  );

  bank_controller u_bank1 (
    .CLK(CLK), .RESET(RESET),
    .cmd_push(cmd_push[1]), .cmd(cmd1), .cmd_high(cmd_high[1]),
    .rd_pop(rd_pop[1]), .rd_valid(rd_valid[1]), .rd_word(rd_word1)
  );

  frame_pacer u_pacer (
    .CLK(CLK), .RESET(RESET),
    .cmd_valid(cmd_valid), .is_start(is_start), .is_stop(is_stop),
    .n_frame_max(n_frame_max), .clk_per_frame(clk_per_frame),
    .cmd_push(cmd_push), .cmd0(cmd0), .cmd1(cmd1), .cmd_high(cmd_high),
    .rd_valid(rd_valid), .rd_word0(rd_word0), .rd_word1(rd_word1),
    .rd_pop(rd_pop),
    .app_running(app_running), .app_error(app_error),
    .frame_count(frame_count)
  );

endmodule

//--- rtl/frame_pacer.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module frame_pacer (
  input  logic                 CLK,
  input  logic                 RESET,
  input  logic                 cmd_valid,
  input  logic                 is_start,
  input  logic                 is_stop,
  input  pacer_pkg::count_t    n_frame_max,
  input  pacer_pkg::count_t    clk_per_frame,
  output logic [1:0]           cmd_push,
  output pacer_pkg::bank_cmd_t cmd0,
  output pacer_pkg::bank_cmd_t cmd1,
  input  logic [1:0]           cmd_high,
  input  logic [1:0]           rd_valid,
  input  pacer_pkg::word_t     rd_word0,
  input  pacer_pkg::word_t     rd_word1,
  output logic [1:0]           rd_pop,
  output logic                 app_running,
  output logic                 app_error,
  output pacer_pkg::count_t    frame_count
);
  import pacer_pkg::*;

  localparam zmw_addr_t LAST_IDX = zmw_addr_t'(`N_ZMW - 1);

  pacer_state_t state;
  count_t       n_frame_q, clk_per_frame_q, n_clock, next_frame;
  zmw_addr_t    wr_idx, rd_idx;
  logic         src, dst;      // bank read this frame, bank written
  logic         cmd_room, pop_en, mismatch, stop_req;
  word_t        src_word;
  bank_cmd_t    cmd_q [2];

  function automatic bank_cmd_t mk_cmd(input bank_op_t o, input word_t w);
    return '{op: o, word: w};
  endfunction

  assign dst        = ~src;
  assign cmd_room   = cmd_high == 2'b00;
  assign src_word   = src ? rd_word1 : rd_word0;
  assign mismatch   = src_word != word_t'(rd_idx);
  assign stop_req   = cmd_valid && is_stop;
  assign pop_en     = state == PS_FRAME && rd_valid[src] && cmd_room && !stop_req;
  assign rd_pop     = src ? {pop_en, 1'b0} : {1'b0, pop_en};
  assign next_frame = frame_count + count_t'(1);
  assign cmd0       = cmd_q[0];
  assign cmd1       = cmd_q[1];

  assign app_running = state >= PS_FRAME_START;
  assign app_error   = state == PS_ERROR;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state       <= PS_STOPPED;
      cmd_push    <= 2'b00;
      frame_count <= '0;
      n_clock     <= '0;
      src         <= 1'b0;
      wr_idx      <= '0;
      rd_idx      <= '0;
    end else begin
      cmd_push <= 2'b00;
      n_clock  <= n_clock + count_t'(1);   // frame period timer
      if (stop_req && state > PS_STOPPING) begin
        state <= PS_STOPPING;
      end else begin
        case (state)
          PS_STOPPED:
            if (cmd_valid && is_start) begin
              n_frame_q       <= n_frame_max;
              clk_per_frame_q <= clk_per_frame;
              frame_count     <= '0;
              wr_idx          <= '0;
              src             <= 1'b0;   // initial list goes into bank 0
              state           <= PS_FILL_START;
            end
          PS_STOPPING:
            if (cmd_room) begin
              cmd_q[0] <= mk_cmd(STOP, '0);
              cmd_q[1] <= mk_cmd(STOP, '0);
              cmd_push <= 2'b11;
              state    <= PS_STOPPED;
            end
          PS_FILL_START:
            if (!cmd_high[0]) begin
              cmd_q[0]    <= mk_cmd(START_WR, '0);
              cmd_push[0] <= 1'b1;
              state       <= PS_FILL;
            end
          PS_FILL:
            if (!cmd_high[0]) begin
              cmd_q[0]    <= mk_cmd(DATA, word_t'(wr_idx));
              cmd_push[0] <= 1'b1;
              wr_idx      <= wr_idx + 1'b1;
              if (wr_idx == LAST_IDX) state <= PS_FILL_END;
            end
          PS_FILL_END:
            if (!cmd_high[0]) begin
              cmd_q[0]    <= mk_cmd(STOP, '0);
              cmd_push[0] <= 1'b1;
              n_clock     <= '0;
              state       <= PS_FRAME_START;
            end
          PS_FRAME_START:
            if (cmd_room) begin
              cmd_q[src] <= mk_cmd(START_RD, '0);
              cmd_q[dst] <= mk_cmd(START_WR, '0);
              cmd_push   <= 2'b11;
              rd_idx     <= '0;
              state      <= PS_FRAME;
            end
          PS_FRAME:
            if (pop_en) begin
              if (mismatch) begin
                cmd_q[0] <= mk_cmd(STOP, '0);
                cmd_q[1] <= mk_cmd(STOP, '0);
                cmd_push <= 2'b11;
                state    <= PS_ERROR;
              end else begin
                cmd_q[dst]    <= mk_cmd(DATA, src_word);   // copy across
                cmd_push[dst] <= 1'b1;
                rd_idx        <= rd_idx + 1'b1;
                if (rd_idx == LAST_IDX) state <= PS_FRAME_END;
              end
            end
          PS_FRAME_END:
            if (cmd_room) begin
              cmd_q[0]    <= mk_cmd(STOP, '0);
              cmd_q[1]    <= mk_cmd(STOP, '0);
              cmd_push    <= 2'b11;
              src         <= dst;          // banks swap roles
              frame_count <= next_frame;
              state       <= (next_frame >= n_frame_q) ? PS_STOPPED : PS_INTERFRAME;
            end
          PS_INTERFRAME:
            // copy may have overrun the period, then start at once
            if (n_clock + count_t'(1) >= clk_per_frame_q) begin
              n_clock <= '0;
              state   <= PS_FRAME_START;
            end
          default: ;                       // error is sticky until reset
        endcase
      end
    end
  end

  // a bank at its high level gets no new command
  assert property (@(posedge CLK) disable iff (RESET) (cmd_push & $past(cmd_high)) == 2'b00)
    else $error("frame_pacer: command pushed to a bank at its high level");

endmodule

//--- rtl/bank_controller.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module bank_controller (
  input  logic                 CLK,
  input  logic                 RESET,
  input  logic                 cmd_push,
  input  pacer_pkg::bank_cmd_t cmd,
  output logic                 cmd_high,
  input  logic                 rd_pop,
  output logic                 rd_valid,
  output pacer_pkg::word_t     rd_word
);
  import pacer_pkg::*;

  localparam int        LAT       = `BRAM_READ_LATENCY;
  localparam zmw_addr_t LAST_ADDR = zmw_addr_t'(`N_ZMW - 1);

  typedef enum logic [1:0] {B_IDLE, B_WRITING, B_READING} bank_state_t;

  bank_state_t    state;
  zmw_addr_t      addr;
  word_t          mem [`N_ZMW];
  word_t          data_pipe [LAT];
  logic [LAT-1:0] valid_pipe;
  logic           draining;     // throwing away reads left by a stopped frame

  bank_cmd_t head;
  logic      head_valid, cmd_take, stop_cmd, wr_en, rd_issue;
  logic      rd_fifo_valid, rd_fifo_high, rd_fifo_pop;

  sync_fifo #(.item_t(bank_cmd_t), .DEPTH(`FIFO_DEPTH)) u_cmd_fifo (
    .CLK(CLK),
    .RESET(RESET),
    .push(cmd_push),
    .din(cmd),
    .pop(cmd_take),
    .dout(head),
    .valid(head_valid),
    .full(),
    .high(cmd_high)
  );

  sync_fifo #(.item_t(word_t), .DEPTH(`FIFO_DEPTH)) u_rd_fifo (
    .CLK(CLK),
    .RESET(RESET),
    .push(valid_pipe[LAT-1]),
    .din(data_pipe[LAT-1]),
    .pop(rd_fifo_pop),
    .dout(rd_word),
    .valid(rd_fifo_valid),
    .full(),
    .high(rd_fifo_high)
  );

  // commands wait until stale read data is gone
  assign cmd_take    = head_valid && !draining;
  assign stop_cmd    = cmd_take && head.op == STOP;
  assign wr_en       = state == B_WRITING && cmd_take && head.op == DATA;
  assign rd_issue    = state == B_READING && !stop_cmd && !rd_fifo_high;
  assign rd_valid    = rd_fifo_valid && !draining;
  assign rd_fifo_pop = draining ? rd_fifo_valid : rd_pop;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state      <= B_IDLE;
      addr       <= '0;
      draining   <= 1'b0;
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= rd_issue;
      for (int i = 1; i < LAT; i++) valid_pipe[i] <= valid_pipe[i-1];

      if (draining && valid_pipe == '0 && !rd_fifo_valid) draining <= 1'b0;

      if (stop_cmd) begin
        state    <= B_IDLE;          // from any state
        draining <= 1'b1;
      end else begin
        case (state)
          B_IDLE:
            if (cmd_take && head.op == START_WR) begin
              addr  <= '0;
              state <= B_WRITING;
            end else if (cmd_take && head.op == START_RD) begin
              addr  <= '0;
              state <= B_READING;
            end
          B_WRITING:
            if (wr_en) addr <= addr + 1'b1;
            else if (cmd_take && head.op == START_WR) addr <= '0;
          default:                   // reading
            if (rd_issue) begin
              addr <= addr + 1'b1;
              if (addr == LAST_ADDR) state <= B_IDLE;
            end
        endcase
      end
    end
  end

  // ram and read pipeline
  always_ff @(posedge CLK) begin
    if (wr_en) mem[addr] <= head.word;
    data_pipe[0] <= mem[addr];
    for (int i = 1; i < LAT; i++) data_pipe[i] <= data_pipe[i-1];
  end

  // the pacer only writes into the bank it is not reading
  assert property (@(posedge CLK) disable iff (RESET)
                   state == B_READING && cmd_take |-> head.op != DATA)
    else $error("bank_controller: DATA command while reading");

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = `FIFO_DEPTH
) (
  input  logic  CLK,
  input  logic  RESET,
  input  logic  push,
  input  item_t din,
  input  logic  pop,
  output item_t dout,
  output logic  valid,
  output logic  full,
  output logic  high
);
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [LVL_W-1:0] level;

  // wrap explicitly so non power of two depths work too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge CLK) begin
    if (push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  assign dout  = mem[rd_ptr];    // head of queue, shown ahead of pop
  assign valid = level != '0;
  assign full  = level == LVL_W'(DEPTH);
  assign high  = level >= LVL_W'(`FIFO_HIGH);

  // producers are meant to back off on high, long before full
  assert property (@(posedge CLK) disable iff (RESET) push |-> !full)
    else $error("sync_fifo: push while full");
  assert property (@(posedge CLK) disable iff (RESET) pop |-> valid)
    else $error("sync_fifo: pop while empty");

endmodule

//--- rtl/msg_assembler.sv
`timescale 1ns/1ps
`include "pacer_consts.svh"

module msg_assembler (
  input  logic                CLK,
  input  logic                RESET,
  input  logic                pc_msg_valid,
  input  logic [`XB_SIZE-1:0] pc_msg,
  output logic                pc_msg_ack,
  output logic                cmd_valid,
  output logic                is_start,
  output logic                is_stop,
  output pacer_pkg::count_t   n_frame_max,
  output pacer_pkg::count_t   clk_per_frame
);
  import pacer_pkg::*;

  typedef enum logic [1:0] {WAIT1, WAIT2, WAIT3} asm_state_t;

  asm_state_t             state;
  logic [2*`XB_SIZE-1:0]  cache;    // first two words
  logic [`MSG_SIZE-1:0]   msg;
  logic                   is_ctrl;

  assign pc_msg_ack = pc_msg_valid;   // host never waits

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state     <= WAIT1;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (pc_msg_valid) begin
        case (state)
          WAIT1: begin
            cache[0 +: `XB_SIZE] <= pc_msg;
            state <= WAIT2;
          end
          WAIT2: begin
            cache[`XB_SIZE +: `XB_SIZE] <= pc_msg;
            state <= WAIT3;
          end
          default: begin
            msg       <= {pc_msg, cache};   // third word on top
            cmd_valid <= 1'b1;
            state     <= WAIT1;
          end
        endcase
      end
    end
  end

  assign is_ctrl       = cmd_valid && !msg[`MSG_TYPE_BIT];
  assign is_start      = is_ctrl && msg[`MSG_START_BIT];
  assign is_stop       = is_ctrl && !msg[`MSG_START_BIT];
  assign n_frame_max   = msg[`N_FRAME_BIT +: `N_FRAME_SIZE];
  assign clk_per_frame = msg[`CLK_PER_FRAME_BIT +: `CLK_PER_FRAME_SIZE];

endmodule

//--- rtl/pacer_pkg.sv
`include "pacer_consts.svh"

package pacer_pkg;

  // one pulse-list entry, zmw index sits in the low bits
  typedef logic [`WORD_SIZE-1:0] word_t;

  typedef logic [`ZMW_ADDR_SIZE-1:0] zmw_addr_t;

  // frame and clock counters share the width of the message fields
  typedef logic [`N_FRAME_SIZE-1:0] count_t;

  typedef enum logic [1:0] {
    STOP,
    START_WR,
    START_RD,
    DATA
  } bank_op_t;

  typedef struct packed {
    bank_op_t op;
    word_t    word;       // payload, only meaningful for DATA
  } bank_cmd_t;

  // order matters, everything from PS_FRAME_START up counts as running
  typedef enum logic [3:0] {
    PS_ERROR, PS_STOPPED, PS_STOPPING,
    PS_FILL_START, PS_FILL, PS_FILL_END,
    PS_FRAME_START, PS_FRAME, PS_FRAME_END, PS_INTERFRAME
  } pacer_state_t;

endpackage

//--- rtl/pacer_consts.svh
`ifndef PACER_CONSTS_SVH
`define PACER_CONSTS_SVH

// host side
`define XB_SIZE             32
`define MSG_SIZE            96      // three host words

// pulse-list banks
`define N_ZMW               128
`define ZMW_ADDR_SIZE       7
`define WORD_SIZE           16
`define BRAM_READ_LATENCY   3       // address to data, in clocks

// fifos
`define FIFO_DEPTH          16
`define FIFO_HIGH           12      // producers back off at this level

// control message layout
`define MSG_TYPE_BIT        0       // 0 = control message
`define MSG_START_BIT       6       // 1 = start, 0 = stop
`define N_FRAME_BIT         8
`define N_FRAME_SIZE        24
`define CLK_PER_FRAME_BIT   32
`define CLK_PER_FRAME_SIZE  24

`endif
